// File: Makefile
# verilator build and run of the soc testbench
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module soc_tb -f compile.f

run: compile
	-./obj_dir/Vsoc_tb > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/soc_sva.sv
`timescale 1ns/1ps

module soc_sva (
  input logic        clk_i,
  input logic        rst_i,
  input logic        nmi_valid_i,
  input logic        nmi_ready_i,
  input logic        nmi_we_i,
  input logic [31:0] nmi_addr_i,
  input logic [31:0] nmi_wdata_i,
  input logic        psel_i,
  input logic        penable_i,
  input logic        pready_i
);

  // master holds the request until ready
  a_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    nmi_valid_i && !nmi_ready_i |=> nmi_valid_i && $stable(nmi_addr_i) &&
    $stable(nmi_we_i) && $stable(nmi_wdata_i))
    else $error("nmi request changed or dropped before ready");

  // ready is a one cycle strobe
  a_ready_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    nmi_ready_i |=> !nmi_ready_i)
    else $error("nmi ready held for more than one cycle");

  // access phase needs a setup cycle before it
  a_penable_setup: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(penable_i) |-> psel_i && $past(psel_i))
    else $error("penable rose without a setup cycle");

  // psel stays until the slave answers
  a_psel_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    psel_i && !pready_i |=> psel_i)
    else $error("psel dropped before pready");

endmodule

// nmi side, apb inputs tied off
bind nmi_bus soc_sva u_nmi_sva (
  .clk_i(clk_i), .rst_i(rst_i),
  .nmi_valid_i(nmi_valid_i), .nmi_ready_i(nmi_ready_o), .nmi_we_i(nmi_we_i),
  .nmi_addr_i(nmi_addr_i), .nmi_wdata_i(nmi_wdata_i),
  .psel_i(1'b0), .penable_i(1'b0), .pready_i(1'b0)
);

// apb side, nmi inputs tied off
bind apb_bridge soc_sva u_apb_sva (
  .clk_i(clk_i), .rst_i(rst_i),
  .nmi_valid_i(1'b0), .nmi_ready_i(1'b0), .nmi_we_i(1'b0),
  .nmi_addr_i(32'd0), .nmi_wdata_i(32'd0),
  .psel_i(psel_o), .penable_i(penable_o), .pready_i(pready_i)
);

// File: bench/soc_tb.sv
`timescale 1ns/1ps

module soc_tb;

  localparam int GPIO_WIDTH = 16;
  localparam int MAX_LAT = 8;
  // bus transfers issued over all tests
  localparam int TRANS_COUNT = 36;
  // idle and polling cycles inside the tests
  localparam int WAIT_CYCLES = 600;
  localparam int TMR_POLL = 400;
  // each transfer costs its start edge, the latency bound and a gap
  localparam int WATCHDOG_NS = (TRANS_COUNT * (MAX_LAT + 3) + WAIT_CYCLES + 60) * 10;

  logic                  clk;
  logic                  rst;
  logic                  nmi_valid;
  soc_pkg::nmi_addr_u    nmi_addr;
  logic                  nmi_we;
  logic [31:0]           nmi_wdata;
  logic                  nmi_ready;
  logic [31:0]           nmi_rdata;
  logic [GPIO_WIDTH-1:0] gpio_in;
  logic [GPIO_WIDTH-1:0] gpio_out;
  logic [GPIO_WIDTH-1:0] gpio_oen;
  logic                  irq_pin;
  logic                  irq;

  int    n_checks;
  int    n_errors;
  int    test_err_base;
  string cur_test;

  soc_top #(.GPIO_WIDTH(GPIO_WIDTH)) DUT (
    .clk_i(clk), .rst_i(rst),
    .nmi_valid_i(nmi_valid), .nmi_addr_i(nmi_addr),
    .nmi_we_i(nmi_we), .nmi_wdata_i(nmi_wdata),
    .nmi_ready_o(nmi_ready), .nmi_rdata_o(nmi_rdata),
    .gpio_in_i(gpio_in), .irq_pin_i(irq_pin),
    .gpio_out_o(gpio_out), .gpio_oen_o(gpio_oen), .irq_o(irq)
  );

  always #5 clk = ~clk;

  // addresses from the memory map
  function automatic logic [31:0] gpio_reg(input logic [15:0] off);
    return {soc_pkg::REGION_NATV, soc_pkg::SLOT_GPIO, off};
  endfunction

  function automatic logic [31:0] irq_reg(input logic [15:0] off);
    return {soc_pkg::REGION_NATV, soc_pkg::SLOT_IRQ, off};
  endfunction

  function automatic logic [31:0] tmr_reg(input logic [11:0] off);
    return {soc_pkg::REGION_APB, 8'h00, soc_pkg::APB_SLOT_TIMER, off};
  endfunction

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("Mismatch in %s (%s): expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_err_base = n_errors;
  endtask

  task automatic end_test();
    $display("%s: %s, %0d errors", cur_test,
             (n_errors == test_err_base) ? "ok" : "failed", n_errors - test_err_base);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // one word transfer with the request held until ready
  task automatic nmi_xfer(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata);
    int lat;
    @(posedge clk);
    nmi_valid <= 1'b1;
    nmi_addr  <= addr;
    nmi_we    <= we;
    nmi_wdata <= wdata;
    lat = 0;
    // first edge where the bus sees valid
    @(posedge clk);
    while (!nmi_ready && lat < MAX_LAT) begin
      @(posedge clk);
      lat++;
    end
    if (!nmi_ready) begin
      n_errors++;
      $display("%s: no ready within %0d cycles for address %h", cur_test, MAX_LAT, addr);
    end
    rdata = nmi_rdata;
    // drop valid in the cycle after ready
    nmi_valid <= 1'b0;
  endtask

  task automatic nmi_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rd_unused;
    nmi_xfer(1'b1, addr, data, rd_unused);
  endtask

  task automatic nmi_read(input logic [31:0] addr, output logic [31:0] data);
    nmi_xfer(1'b0, addr, 32'd0, data);
  endtask

  task automatic test_reset();
    logic [31:0] rd;
    start_test("reset_values");
    nmi_read(gpio_reg(soc_pkg::GPIO_OUT), rd);
    check_eq("GPIO_OUT", 32'd0, rd);
    nmi_read(gpio_reg(soc_pkg::GPIO_OEN), rd);
    check_eq("GPIO_OEN", 32'd0, rd);
    nmi_read(irq_reg(soc_pkg::IRQ_EN), rd);
    check_eq("IRQ_EN", 32'd0, rd);
    nmi_read(irq_reg(soc_pkg::IRQ_PEND), rd);
    check_eq("IRQ_PEND", 32'd0, rd);
    check_eq("irq_o", 32'd0, 32'(irq));
    check_eq("gpio_out_o", 32'd0, 32'(gpio_out));
    check_eq("gpio_oen_o", 32'd0, 32'(gpio_oen));
    end_test();
  endtask

  task automatic test_gpio();
    logic [31:0]           rd;
    logic [GPIO_WIDTH-1:0] out_val;
    logic [GPIO_WIDTH-1:0] oen_val;
    logic [GPIO_WIDTH-1:0] in_val;
    logic [GPIO_WIDTH-1:0] junk_val;
    start_test("gpio_regs");
    out_val  = GPIO_WIDTH'($urandom());
    oen_val  = ~out_val;
    in_val   = GPIO_WIDTH'($urandom());
    junk_val = ~in_val;
    nmi_write(gpio_reg(soc_pkg::GPIO_OUT), 32'(out_val));
    check_eq("gpio_out_o", 32'(out_val), 32'(gpio_out));
    nmi_read(gpio_reg(soc_pkg::GPIO_OUT), rd);
    check_eq("GPIO_OUT readback", 32'(out_val), rd);
    nmi_write(gpio_reg(soc_pkg::GPIO_OEN), 32'(oen_val));
    check_eq("gpio_oen_o", 32'(oen_val), 32'(gpio_oen));
    nmi_read(gpio_reg(soc_pkg::GPIO_OEN), rd);
    check_eq("GPIO_OEN readback", 32'(oen_val), rd);
    // input pins pass a two flop sync
    @(posedge clk);
    gpio_in <= in_val;
    wait_cycles(4);
    nmi_read(gpio_reg(soc_pkg::GPIO_IN), rd);
    check_eq("GPIO_IN", 32'(in_val), rd);
    // read only register keeps the pin value
    nmi_write(gpio_reg(soc_pkg::GPIO_IN), 32'(junk_val));
    nmi_read(gpio_reg(soc_pkg::GPIO_IN), rd);
    check_eq("GPIO_IN after write", 32'(in_val), rd);
    check_eq("gpio_out_o kept", 32'(out_val), 32'(gpio_out));
    end_test();
  endtask

  task automatic test_timer();
    logic [31:0] rd;
    logic [31:0] c1;
    logic [31:0] c2;
    start_test("timer");
    nmi_write(tmr_reg(soc_pkg::TMR_CMP), 32'd1000);
    nmi_read(tmr_reg(soc_pkg::TMR_CMP), rd);
    check_eq("TMR_CMP readback", 32'd1000, rd);
    nmi_write(tmr_reg(soc_pkg::TMR_CTRL), 32'd1);
    nmi_read(tmr_reg(soc_pkg::TMR_CNT), c1);
    nmi_read(tmr_reg(soc_pkg::TMR_CNT), c2);
    // stop it well before the compare value
    nmi_write(tmr_reg(soc_pkg::TMR_CTRL), 32'd0);
    // enabled counter moves on between the two reads
    check_eq("count increasing", 32'd1, 32'(c2 > c1));
    check_eq("count below compare", 32'd1, 32'(c2 < 32'd1000));
    end_test();
  endtask

  task automatic test_irq();
    logic [31:0] rd;
    int          lat;
    start_test("interrupts");
    // external pin pends but stays masked
    @(posedge clk);
    irq_pin <= 1'b1;
    @(posedge clk);
    irq_pin <= 1'b0;
    nmi_read(irq_reg(soc_pkg::IRQ_PEND), rd);
    check_eq("pend ext", 32'd1 << soc_pkg::IRQ_EXT, rd);
    check_eq("irq_o masked", 32'd0, 32'(irq));
    nmi_write(irq_reg(soc_pkg::IRQ_EN), 32'd1 << soc_pkg::IRQ_EXT);
    wait_cycles(2);
    check_eq("irq_o ext enabled", 32'd1, 32'(irq));
    nmi_write(irq_reg(soc_pkg::IRQ_PEND), 32'd1 << soc_pkg::IRQ_EXT);
    nmi_read(irq_reg(soc_pkg::IRQ_PEND), rd);
    check_eq("pend ext cleared", 32'd0, rd);
    check_eq("irq_o after ext clear", 32'd0, 32'(irq));
    // gpio rising edge on bit 0 with its source masked in IRQ_EN
    @(posedge clk);
    gpio_in <= '0;
    wait_cycles(4);
    nmi_write(gpio_reg(soc_pkg::GPIO_IEN), 32'd1);
    @(posedge clk);
    gpio_in <= GPIO_WIDTH'(1);
    wait_cycles(6);
    nmi_read(irq_reg(soc_pkg::IRQ_PEND), rd);
    check_eq("pend gpio", 32'd1 << soc_pkg::IRQ_GPIO, rd);
    check_eq("irq_o gpio masked", 32'd0, 32'(irq));
    nmi_write(irq_reg(soc_pkg::IRQ_PEND), 32'd1 << soc_pkg::IRQ_GPIO);
    nmi_read(irq_reg(soc_pkg::IRQ_PEND), rd);
    check_eq("pend gpio cleared", 32'd0, rd);
    // enabled timer source reaches irq_o
    nmi_write(irq_reg(soc_pkg::IRQ_EN), 32'd1 << soc_pkg::IRQ_TIMER);
    nmi_write(tmr_reg(soc_pkg::TMR_CMP), 32'd200);
    nmi_write(tmr_reg(soc_pkg::TMR_CTRL), 32'd1);
    lat = 0;
    while (!irq && lat < TMR_POLL) begin
      @(posedge clk);
      lat++;
    end
    if (!irq) begin
      n_errors++;
      $display("%s: timer interrupt did not reach irq_o within %0d cycles", cur_test, TMR_POLL);
    end
    nmi_read(irq_reg(soc_pkg::IRQ_PEND), rd);
    check_eq("pend timer", 32'd1 << soc_pkg::IRQ_TIMER, rd);
    // stop the timer before clearing so no new pulse lands
    nmi_write(tmr_reg(soc_pkg::TMR_CTRL), 32'd0);
    nmi_write(irq_reg(soc_pkg::IRQ_PEND), 32'd1 << soc_pkg::IRQ_TIMER);
    nmi_read(irq_reg(soc_pkg::IRQ_PEND), rd);
    check_eq("pend timer cleared", 32'd0, rd);
    check_eq("irq_o after timer clear", 32'd0, 32'(irq));
    end_test();
  endtask

  task automatic test_unmapped();
    logic [31:0] rd;
    start_test("unmapped");
    // unknown region
    nmi_read(32'h0400_0000, rd);
    check_eq("bad region", soc_pkg::BUS_ERR_WORD, rd);
    // free slot in the native region
    nmi_read({soc_pkg::REGION_NATV, 8'h05, 16'h0000}, rd);
    check_eq("bad native slot", soc_pkg::BUS_ERR_WORD, rd);
    // free slot in the apb region
    nmi_read({soc_pkg::REGION_APB, 8'h00, 4'h1, 12'h000}, rd);
    check_eq("bad apb slot", soc_pkg::BUS_ERR_WORD, rd);
    nmi_write(32'h0400_0010, 32'h1234_5678);
    end_test();
  endtask

  initial begin
    void'($urandom(32'h9b2f_2765));
    n_checks  = 0;
    n_errors  = 0;
    clk       = 1'b0;
    rst       = 1'b1;
    nmi_valid = 1'b0;
    nmi_addr  = '0;
    nmi_we    = 1'b0;
    nmi_wdata = 32'd0;
    gpio_in   = '0;
    irq_pin   = 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    test_reset();
    test_gpio();
    test_timer();
    test_irq();
    test_unmapped();
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // watchdog sized from transfer count and test waits
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: common/soc_pkg.sv
package soc_pkg;

  // regions live in address bits 31:24
  localparam logic [7:0] REGION_NATV = 8'h02;
  localparam logic [7:0] REGION_APB = 8'h03;

  // native slots in bits 23:16
  localparam logic [7:0] SLOT_GPIO = 8'h00;
  localparam logic [7:0] SLOT_IRQ = 8'h01;

  // apb slots in bits 15:12
  localparam logic [3:0] APB_SLOT_TIMER = 4'h0;

  // gpio register offsets
  localparam logic [15:0] GPIO_OUT = 16'h0000;
  localparam logic [15:0] GPIO_OEN = 16'h0004;
  localparam logic [15:0] GPIO_IN = 16'h0008;
  localparam logic [15:0] GPIO_IEN = 16'h000c;

  // interrupt controller offsets
  localparam logic [15:0] IRQ_PEND = 16'h0000;
  localparam logic [15:0] IRQ_EN = 16'h0004;

  // timer offsets, apb register field
  localparam logic [11:0] TMR_CTRL = 12'h000;
  localparam logic [11:0] TMR_CMP = 12'h004;
  localparam logic [11:0] TMR_CNT = 12'h008;

  // interrupt sources and their pending bits
  localparam int IRQ_NUM = 3;
  localparam int IRQ_EXT = 0;
  localparam int IRQ_GPIO = 1;
  localparam int IRQ_TIMER = 2;

  // read data of unmapped accesses
  localparam logic [31:0] BUS_ERR_WORD = 32'hdead_beef;

  // native view of a bus address
  typedef struct packed {
    logic [7:0]  region;
    logic [7:0]  slot;
    logic [15:0] offset;
  } natv_addr_t;

  // apb view of the same word
  typedef struct packed {
    logic [7:0]  region;
    logic [7:0]  unused;
    logic [3:0]  slot;
    logic [11:0] regoff;
  } apb_addr_t;

  typedef union packed {
    natv_addr_t natv;
    apb_addr_t  apb;
  } nmi_addr_u;

endpackage

// File: compile.f
common/soc_pkg.sv
design/bus/nmi_bus.sv
design/bus/apb_bridge.sv
design/natv/natv_gpio.sv
design/natv/irq_ctrl.sv
design/apb/apb_timer.sv
design/soc_top.sv
bench/soc_sva.sv
bench/soc_tb.sv

// File: design/apb/apb_timer.sv
`timescale 1ns/1ps

module apb_timer (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic [11:0] paddr_i,
  input  logic        pwrite_i,
  input  logic [31:0] pwdata_i,
  output logic        pready_o,
  output logic [31:0] prdata_o,
  output logic        irq_o
);

  logic        s_access;
  logic        s_en;
  logic [31:0] s_cmp;
  logic [31:0] s_cnt;
  logic        s_hit;

  // no wait states
  assign s_access = psel_i & penable_i;
  assign pready_o = s_access;

  assign s_hit = (s_cnt == s_cmp);

  // register writes in the access cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s_en  <= 1'b0;
      s_cmp <= '0;
    end else if (s_access && pwrite_i) begin
      case (paddr_i)
        soc_pkg::TMR_CTRL: s_en <= pwdata_i[0];
        soc_pkg::TMR_CMP:  s_cmp <= pwdata_i;
        // count is read only
        default: ;
      endcase
    end
  end

  // counter wraps at compare
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s_cnt <= '0;
      irq_o <= 1'b0;
    end else begin
      irq_o <= s_en & s_hit;
      if (s_en) begin
        if (s_hit) begin
          s_cnt <= '0;
        end else begin
          s_cnt <= s_cnt + 32'd1;
        end
      end
    end
  end

  // read mux
  always_comb begin
    case (paddr_i)
      soc_pkg::TMR_CTRL: prdata_o = {31'd0, s_en};
      soc_pkg::TMR_CMP:  prdata_o = s_cmp;
      soc_pkg::TMR_CNT:  prdata_o = s_cnt;
      default: prdata_o = '0;
    endcase
  end

endmodule

// File: design/bus/apb_bridge.sv
`timescale 1ns/1ps

module apb_bridge (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               sel_i,
  input  soc_pkg::nmi_addr_u addr_i,
  input  logic               we_i,
  input  logic [31:0]        wdata_i,
  output logic               ready_o,
  output logic [31:0]        rdata_o,
  output logic               psel_o,
  output logic               penable_o,
  output logic [11:0]        paddr_o,
  output logic               pwrite_o,
  output logic [31:0]        pwdata_o,
  input  logic               pready_i,
  input  logic [31:0]        prdata_i
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_SETUP = 2'd1;
  localparam logic [1:0] ST_ACCESS = 2'd2;

  logic [1:0] s_state;

  // control path
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s_state   <= ST_IDLE;
      psel_o    <= 1'b0;
      penable_o <= 1'b0;
      ready_o   <= 1'b0;
    end else begin
      // ready is a single cycle strobe
      ready_o <= 1'b0;
      case (s_state)
        ST_IDLE: begin
          if (sel_i) begin
            psel_o  <= 1'b1;
            s_state <= ST_SETUP;
          end
        end
        ST_SETUP: begin
          penable_o <= 1'b1;
          s_state   <= ST_ACCESS;
        end
        ST_ACCESS: begin
          // wait states allowed by the protocol
          if (pready_i) begin
            psel_o    <= 1'b0;
            penable_o <= 1'b0;
            ready_o   <= 1'b1;
            s_state   <= ST_IDLE;
          end
        end
        default: begin
          s_state <= ST_IDLE;
        end
      endcase
    end
  end

  // request captured at sel and held through setup and access
  always_ff @(posedge clk_i) begin
    if (s_state == ST_IDLE && sel_i) begin
      paddr_o  <= addr_i.apb.regoff;
      pwrite_o <= we_i;
      pwdata_o <= wdata_i;
    end
    if (s_state == ST_ACCESS && pready_i) begin
      rdata_o <= prdata_i;
    end
  end

endmodule

// File: design/bus/nmi_bus.sv
`timescale 1ns/1ps

module nmi_bus (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              nmi_valid_i,
  input  soc_pkg::nmi_addr_u nmi_addr_i,
  input  logic              nmi_we_i,
  input  logic [31:0]       nmi_wdata_i,
  output logic              nmi_ready_o,
  output logic [31:0]       nmi_rdata_o,
  output logic              gpio_sel_o,
  input  logic              gpio_ready_i,
  input  logic [31:0]       gpio_rdata_i,
  output logic              irq_sel_o,
  input  logic              irq_ready_i,
  input  logic [31:0]       irq_rdata_i,
  output logic              apb_sel_o,
  input  logic              apb_ready_i,
  input  logic [31:0]       apb_rdata_i,
  output soc_pkg::nmi_addr_u req_addr_o,
  output logic              req_we_o,
  output logic [31:0]       req_wdata_o
);

  // target codes kept until the next request
  localparam logic [1:0] TGT_GPIO = 2'd0;
  localparam logic [1:0] TGT_IRQ = 2'd1;
  localparam logic [1:0] TGT_APB = 2'd2;
  localparam logic [1:0] TGT_ERR = 2'd3;

  logic       s_hit_gpio;
  logic       s_hit_irq;
  logic       s_hit_apb;
  logic       s_start;
  logic       s_busy;
  logic       s_done;
  logic       s_err_sel_q;
  logic       s_err_ready_q;
  logic [1:0] s_tgt_q;

  // native slots through the natv view
  assign s_hit_gpio = (nmi_addr_i.natv.region == soc_pkg::REGION_NATV) &&
                      (nmi_addr_i.natv.slot == soc_pkg::SLOT_GPIO);
  assign s_hit_irq  = (nmi_addr_i.natv.region == soc_pkg::REGION_NATV) &&
                      (nmi_addr_i.natv.slot == soc_pkg::SLOT_IRQ);
  // apb slot through the apb view
  assign s_hit_apb  = (nmi_addr_i.apb.region == soc_pkg::REGION_APB) &&
                      (nmi_addr_i.apb.unused == 8'h00) &&
                      (nmi_addr_i.apb.slot == soc_pkg::APB_SLOT_TIMER);

  // accept only a fresh request
  assign s_start = nmi_valid_i & ~s_busy & ~s_done;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gpio_sel_o    <= 1'b0;
      irq_sel_o     <= 1'b0;
      apb_sel_o     <= 1'b0;
      s_err_sel_q   <= 1'b0;
      s_err_ready_q <= 1'b0;
      s_busy        <= 1'b0;
      s_done        <= 1'b0;
      s_tgt_q       <= TGT_ERR;
    end else begin
      // one cycle select pulses
      gpio_sel_o    <= s_start & s_hit_gpio;
      irq_sel_o     <= s_start & s_hit_irq;
      apb_sel_o     <= s_start & s_hit_apb;
      s_err_sel_q   <= s_start & ~(s_hit_gpio | s_hit_irq | s_hit_apb);
      // unmapped answer one cycle after its select
      s_err_ready_q <= s_err_sel_q;
      if (s_start) begin
        s_busy <= 1'b1;
        if (s_hit_gpio) begin
          s_tgt_q <= TGT_GPIO;
        end else if (s_hit_irq) begin
          s_tgt_q <= TGT_IRQ;
        end else if (s_hit_apb) begin
          s_tgt_q <= TGT_APB;
        end else begin
          s_tgt_q <= TGT_ERR;
        end
      end else if (nmi_ready_o) begin
        s_busy <= 1'b0;
      end
      // hold off until the master drops valid
      if (nmi_ready_o) begin
        s_done <= 1'b1;
      end else if (!nmi_valid_i) begin
        s_done <= 1'b0;
      end
    end
  end

  // forwarded request, payload only
  always_ff @(posedge clk_i) begin
    if (s_start) begin
      req_addr_o  <= nmi_addr_i;
      req_we_o    <= nmi_we_i;
      req_wdata_o <= nmi_wdata_i;
    end
  end

  // response mux
  always_comb begin
    case (s_tgt_q)
      TGT_GPIO: begin
        nmi_ready_o = gpio_ready_i;
        nmi_rdata_o = gpio_rdata_i;
      end
      TGT_IRQ: begin
        nmi_ready_o = irq_ready_i;
        nmi_rdata_o = irq_rdata_i;
      end
      TGT_APB: begin
        nmi_ready_o = apb_ready_i;
        nmi_rdata_o = apb_rdata_i;
      end
      default: begin
        nmi_ready_o = s_err_ready_q;
        nmi_rdata_o = soc_pkg::BUS_ERR_WORD;
      end
    endcase
  end

endmodule

// File: design/natv/irq_ctrl.sv
`timescale 1ns/1ps

module irq_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        sel_i,
  input  logic [15:0]                 addr_i,
  input  logic                        we_i,
  input  logic [31:0]                 wdata_i,
  input  logic [soc_pkg::IRQ_NUM-1:0] irq_src_i,
  output logic                        ready_o,
  output logic [31:0]                 rdata_o,
  output logic                        irq_o
);

  logic [soc_pkg::IRQ_NUM-1:0] s_pend;
  logic [soc_pkg::IRQ_NUM-1:0] s_en;
  logic [soc_pkg::IRQ_NUM-1:0] s_clr;

  // write one to clear mask
  assign s_clr = (sel_i && we_i && addr_i == soc_pkg::IRQ_PEND) ?
                 wdata_i[soc_pkg::IRQ_NUM-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s_pend  <= '0;
      s_en    <= '0;
      ready_o <= 1'b0;
      irq_o   <= 1'b0;
    end else begin
      ready_o <= sel_i;
      // a live source beats the clear
      s_pend  <= (s_pend & ~s_clr) | irq_src_i;
      if (sel_i && we_i && addr_i == soc_pkg::IRQ_EN) begin
        s_en <= wdata_i[soc_pkg::IRQ_NUM-1:0];
      end
      // registered request line
      irq_o <= |(s_pend & s_en);
    end
  end

  // read data
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      case (addr_i)
        soc_pkg::IRQ_PEND: rdata_o <= {{(32-soc_pkg::IRQ_NUM){1'b0}}, s_pend};
        soc_pkg::IRQ_EN:   rdata_o <= {{(32-soc_pkg::IRQ_NUM){1'b0}}, s_en};
        default: rdata_o <= '0;
      endcase
    end
  end

endmodule

// File: design/natv/natv_gpio.sv
`timescale 1ns/1ps

module natv_gpio #(
  parameter int GPIO_WIDTH = 16
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  sel_i,
  input  logic [15:0]           addr_i,
  input  logic                  we_i,
  input  logic [31:0]           wdata_i,
  input  logic [GPIO_WIDTH-1:0] gpio_in_i,
  output logic                  ready_o,
  output logic [31:0]           rdata_o,
  output logic [GPIO_WIDTH-1:0] gpio_out_o,
  output logic [GPIO_WIDTH-1:0] gpio_oen_o,
  output logic                  irq_o
);

  logic [GPIO_WIDTH-1:0] s_ien;
  logic [GPIO_WIDTH-1:0] s_sync1;
  logic [GPIO_WIDTH-1:0] s_sync2;
  logic [GPIO_WIDTH-1:0] s_prev;
  logic [GPIO_WIDTH-1:0] s_rise;
  logic [31:0]           s_rd;

  // two flop input sync, then one more for edge detect
  always_ff @(posedge clk_i) begin
    s_sync1 <= gpio_in_i;
    s_sync2 <= s_sync1;
    s_prev  <= s_sync2;
  end

  assign s_rise = s_sync2 & ~s_prev & s_ien;

  // registers and slave handshake
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gpio_out_o <= '0;
      gpio_oen_o <= '0;
      s_ien      <= '0;
      ready_o    <= 1'b0;
      irq_o      <= 1'b0;
    end else begin
      ready_o <= sel_i;
      irq_o   <= |s_rise;
      if (sel_i && we_i) begin
        // gpio_in is read only
        case (addr_i)
          soc_pkg::GPIO_OUT: gpio_out_o <= wdata_i[GPIO_WIDTH-1:0];
          soc_pkg::GPIO_OEN: gpio_oen_o <= wdata_i[GPIO_WIDTH-1:0];
          soc_pkg::GPIO_IEN: s_ien <= wdata_i[GPIO_WIDTH-1:0];
          default: ;
        endcase
      end
    end
  end

  // read mux, zero extended
  always_comb begin
    s_rd = '0;
    case (addr_i)
      soc_pkg::GPIO_OUT: s_rd[GPIO_WIDTH-1:0] = gpio_out_o;
      soc_pkg::GPIO_OEN: s_rd[GPIO_WIDTH-1:0] = gpio_oen_o;
      soc_pkg::GPIO_IN:  s_rd[GPIO_WIDTH-1:0] = s_sync2;
      soc_pkg::GPIO_IEN: s_rd[GPIO_WIDTH-1:0] = s_ien;
      default: s_rd = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rdata_o <= s_rd;
    end
  end

endmodule

// File: design/soc_top.sv
`timescale 1ns/1ps

module soc_top #(
  parameter int GPIO_WIDTH = 16
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  nmi_valid_i,
  input  soc_pkg::nmi_addr_u    nmi_addr_i,
  input  logic                  nmi_we_i,
  input  logic [31:0]           nmi_wdata_i,
  output logic                  nmi_ready_o,
  output logic [31:0]           nmi_rdata_o,
  input  logic [GPIO_WIDTH-1:0] gpio_in_i,
  input  logic                  irq_pin_i,
  output logic [GPIO_WIDTH-1:0] gpio_out_o,
  output logic [GPIO_WIDTH-1:0] gpio_oen_o,
  output logic                  irq_o
);

  // forwarded request
  soc_pkg::nmi_addr_u s_req_addr;
  logic               s_req_we;
  logic [31:0]        s_req_wdata;
  // native slaves
  logic               s_gpio_sel, s_gpio_ready;
  logic [31:0]        s_gpio_rdata;
  logic               s_irq_sel, s_irq_ready;
  logic [31:0]        s_irq_rdata;
  // bridge and apb
  logic               s_apb_sel, s_apb_ready;
  logic [31:0]        s_apb_rdata;
  logic               s_psel, s_penable, s_pwrite, s_pready;
  logic [11:0]        s_paddr;
  logic [31:0]        s_pwdata, s_prdata;
  // interrupt sources
  logic               s_gpio_irq, s_tmr_irq;
  logic [soc_pkg::IRQ_NUM-1:0] s_irq_src;

  assign s_irq_src[soc_pkg::IRQ_EXT]   = irq_pin_i;
  assign s_irq_src[soc_pkg::IRQ_GPIO]  = s_gpio_irq;
  assign s_irq_src[soc_pkg::IRQ_TIMER] = s_tmr_irq;

  nmi_bus u_nmi_bus (
    .clk_i(clk_i), .rst_i(rst_i),
    .nmi_valid_i(nmi_valid_i), .nmi_addr_i(nmi_addr_i),
    .nmi_we_i(nmi_we_i), .nmi_wdata_i(nmi_wdata_i),
    .nmi_ready_o(nmi_ready_o), .nmi_rdata_o(nmi_rdata_o),
    .gpio_sel_o(s_gpio_sel), .gpio_ready_i(s_gpio_ready), .gpio_rdata_i(s_gpio_rdata),
    .irq_sel_o(s_irq_sel), .irq_ready_i(s_irq_ready), .irq_rdata_i(s_irq_rdata),
    .apb_sel_o(s_apb_sel), .apb_ready_i(s_apb_ready), .apb_rdata_i(s_apb_rdata),
    .req_addr_o(s_req_addr), .req_we_o(s_req_we), .req_wdata_o(s_req_wdata)
  );

  apb_bridge u_apb_bridge (
    .clk_i(clk_i), .rst_i(rst_i),
    .sel_i(s_apb_sel), .addr_i(s_req_addr), .we_i(s_req_we), .wdata_i(s_req_wdata),
    .ready_o(s_apb_ready), .rdata_o(s_apb_rdata),
    .psel_o(s_psel), .penable_o(s_penable), .paddr_o(s_paddr),
    .pwrite_o(s_pwrite), .pwdata_o(s_pwdata),
    .pready_i(s_pready), .prdata_i(s_prdata)
  );

  natv_gpio #(.GPIO_WIDTH(GPIO_WIDTH)) u_natv_gpio (
    .clk_i(clk_i), .rst_i(rst_i),
    .sel_i(s_gpio_sel), .addr_i(s_req_addr.natv.offset),
    .we_i(s_req_we), .wdata_i(s_req_wdata), .gpio_in_i(gpio_in_i),
    .ready_o(s_gpio_ready), .rdata_o(s_gpio_rdata),
    .gpio_out_o(gpio_out_o), .gpio_oen_o(gpio_oen_o), .irq_o(s_gpio_irq)
  );

  irq_ctrl u_irq_ctrl (
    .clk_i(clk_i), .rst_i(rst_i),
    .sel_i(s_irq_sel), .addr_i(s_req_addr.natv.offset),
    .we_i(s_req_we), .wdata_i(s_req_wdata), .irq_src_i(s_irq_src),
    .ready_o(s_irq_ready), .rdata_o(s_irq_rdata), .irq_o(irq_o)
  );

  apb_timer u_apb_timer (
    .clk_i(clk_i), .rst_i(rst_i),
    .psel_i(s_psel), .penable_i(s_penable), .paddr_i(s_paddr),
    .pwrite_i(s_pwrite), .pwdata_i(s_pwdata),
    .pready_o(s_pready), .prdata_o(s_prdata), .irq_o(s_tmr_irq)
  );

endmodule
